// ==== sim.f ====
+incdir+.
link_pkg.sv
link_decode.sv
link_exec.sv
link_result.sv
mcu_link.sv
mcu_link_checker.sv
tb_mcu_link.sv

// ==== Makefile ====
# Verilator build and run for the mailbox link testbench

VERILATOR ?= verilator
TOP       ?= tb_mcu_link
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert

BIN  := $(OBJ_DIR)/V$(TOP)
SRCS := $(filter-out +%,$(shell cat $(FILELIST)))
HDRS := link_macros.svh

.PHONY: all build run clean

all: run

build: $(BIN)

# Rebuilt only when a source, the header or the file list changes
$(BIN): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

# Exit status of the simulator is the test result
run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)

// ==== tb_mcu_link.sv ====
// Mailbox link testbench: host credit model, reference mailbox and response checks
`timescale 1ns/1ps
`default_nettype none

`include "link_macros.svh"

module tb_mcu_link;

    logic                clk24;
    logic                arst_n;
    logic                req_valid;
    link_pkg::link_req_t req;
    logic                req_credit;
    logic                rsp_valid;
    link_pkg::link_rsp_t rsp;
    logic                rsp_credit;
    logic                irq;
    logic                irq_ack;

    integer      seed;
    int          host_credits;
    int          credits_back;
    int          issued = 0;
    int          cycles = 0;
    logic        hold_rsp;
    logic [15:0] model;
    logic [15:0] exp_q [$];

    mcu_link uut (
        .clk24      ( clk24      ),
        .arst_n     ( arst_n     ),
        .req_valid  ( req_valid  ),
        .req        ( req        ),
        .req_credit ( req_credit ),
        .rsp_valid  ( rsp_valid  ),
        .rsp        ( rsp        ),
        .rsp_credit ( rsp_credit ),
        .irq        ( irq        ),
        .irq_ack    ( irq_ack    )
    );

    always #50 clk24 = ~clk24;

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display(">>> FAIL");
        $fatal(1, "simulation stopped on the first error");
    endtask

    // Host side view of the request credits
    always @(posedge clk24 or negedge arst_n) begin
        if (!arst_n) begin
            host_credits <= `LINK_QDEPTH;
            credits_back <= 0;
        end else begin
            host_credits <= host_credits - int'(req_valid) + int'(req_credit);
            credits_back <= credits_back + int'(req_credit);
        end
    end

    always @(posedge clk24) begin : rsp_check
        logic [15:0] want;
        if (arst_n && rsp_valid) begin
            assert (!hold_rsp) else fail_now("response sent while the host held back credits");
            assert (exp_q.size() > 0) else fail_now("response arrived with no read outstanding");
            want = exp_q.pop_front();
            assert (rsp.data == want)
                else fail_now($sformatf("FAIL %0t: read expected %h got %h",
                                        $time, want, rsp.data));
        end
    end

    // Watchdog scaled by the number of requests sent so far
    always @(posedge clk24) begin
        cycles <= cycles + 1;
        if (cycles > 4 * issued + 200) begin
            fail_now($sformatf("timeout after %0d cycles waiting on the DUT", cycles));
        end
    end

    // Called on a falling edge and returns on the next one
    task automatic send_req(input link_pkg::link_op_e op, input logic [1:0] dsn,
                            input logic [15:0] data);
        while (host_credits == 0) begin
            @(negedge clk24);
        end
        req_valid = 1'b1;
        req       = '{op: op, dsn: dsn, data: data};
        issued++;
        if (op == link_pkg::OP_WRITE) begin
            if (!dsn[1]) begin
                model[15:8] = data[15:8];
            end
            if (!dsn[0]) begin
                model[7:0] = data[7:0];
            end
        end else if (op == link_pkg::OP_READ) begin
            exp_q.push_back(model);
            rsp_credit = !hold_rsp;
        end
        @(negedge clk24);
        req_valid  = 1'b0;
        rsp_credit = 1'b0;
    endtask

    task automatic wait_idle();
        while (exp_q.size() != 0 || host_credits != `LINK_QDEPTH) begin
            @(negedge clk24);
        end
    endtask

    task automatic check_quiet(input int n);
        repeat (n) begin
            @(negedge clk24);
            assert (!req_credit && !rsp_valid && !irq)
                else fail_now($sformatf("FAIL %0t: outputs not low around reset", $time));
        end
    endtask

    initial begin
        int i;
        seed       = 3;
        clk24      = 1'b0;
        arst_n     = 1'b0;
        req_valid  = 1'b0;
        req        = '0;
        rsp_credit = 1'b0;
        irq_ack    = 1'b0;
        hold_rsp   = 1'b0;
        model      = '0;
        check_quiet(8);
        arst_n = 1'b1;
        check_quiet(4);

        // First read sees the cleared mailbox
        send_req(link_pkg::OP_READ, 2'b11, 16'h0000);
        wait_idle();

        // Every lane pattern including no-lane writes
        for (i = 0; i < 12; i++) begin
            send_req(link_pkg::OP_WRITE, 2'(i), 16'($random(seed)));
            send_req(link_pkg::OP_READ, 2'b11, 16'h0000);
        end
        wait_idle();

        // Back-to-back bursts on a full set of credits
        repeat (2) begin
            wait_idle();
            send_req(link_pkg::OP_WRITE, 2'($random(seed)), 16'($random(seed)));
            send_req(link_pkg::OP_READ, 2'b11, 16'h0000);
            send_req(link_pkg::OP_WRITE, 2'($random(seed)), 16'($random(seed)));
            send_req(link_pkg::OP_READ, 2'b11, 16'h0000);
        end
        wait_idle();

        // Four reads fill result while one sits in execute and the sixth stays queued
        hold_rsp = 1'b1;
        repeat (6) send_req(link_pkg::OP_READ, 2'b11, 16'h0000);
        repeat (20) @(negedge clk24);
        assert (host_credits == `LINK_QDEPTH - 1)
            else fail_now($sformatf("FAIL %0t: host credits %0d under back-pressure",
                                    $time, host_credits));
        hold_rsp = 1'b0;
        repeat (6) begin
            rsp_credit = 1'b1;
            @(negedge clk24);
        end
        rsp_credit = 1'b0;
        wait_idle();

        // Interrupt set and ack
        send_req(link_pkg::OP_IRQ, 2'b11, 16'h0000);
        while (!irq) @(negedge clk24);
        irq_ack = 1'b1;
        @(negedge clk24);
        irq_ack = 1'b0;
        assert (!irq)
            else fail_now($sformatf("FAIL %0t: irq still high after the ack", $time));

        // Ack held across the retire so the set must win
        irq_ack = 1'b1;
        send_req(link_pkg::OP_IRQ, 2'b11, 16'h0000);
        while (!irq) @(negedge clk24);
        irq_ack = 1'b0;
        @(negedge clk24);
        assert (irq)
            else fail_now($sformatf("FAIL %0t: irq low after ack and IRQ retired together",
                                    $time));
        irq_ack = 1'b1;
        @(negedge clk24);
        irq_ack = 1'b0;
        assert (!irq)
            else fail_now($sformatf("FAIL %0t: irq still high after the second ack", $time));
        wait_idle();

        assert (credits_back == issued)
            else fail_now($sformatf("FAIL %0t: %0d credit pulses for %0d requests",
                                    $time, credits_back, issued));
        $display(">>> PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== mcu_link_checker.sv ====
// Mailbox link checker: concurrent assertions on credit flow and the MCU interrupt latch
`timescale 1ns/1ps
`default_nettype none

`include "link_macros.svh"

module mcu_link_checker (
    input logic clk24,
    input logic arst_n,
    input logic req_valid,
    input logic req_credit,
    input logic rsp_valid,
    input logic rsp_credit,
    input logic irq,
    input logic irq_ack,
    input logic irq_set
);

    // Requests not yet credited back and host grants not yet used
    logic [3:0] outstanding;
    logic [3:0] grants;

    always_ff @(posedge clk24 or negedge arst_n) begin
        if (!arst_n) begin
            outstanding <= '0;
            grants      <= '0;
        end else begin
            outstanding <= outstanding + 4'(req_valid) - 4'(req_credit);
            grants      <= grants + 4'(rsp_credit) - 4'(rsp_valid);
        end
    end

    assert property (@(posedge clk24) disable iff (!arst_n)
        outstanding <= 4'(`LINK_QDEPTH))
        else $error("more requests outstanding than the request queue holds");

    assert property (@(posedge clk24) disable iff (!arst_n)
        rsp_valid |-> (grants != '0))
        else $error("response sent without a host grant");

    assert property (@(posedge clk24) !arst_n |=> !irq)
        else $error("irq high right after reset");

    // A set in the same cycle keeps the latch high
    assert property (@(posedge clk24) disable iff (!arst_n)
        (irq_ack && !irq_set) |=> !irq)
        else $error("irq did not fall one cycle after the ack");

endmodule

bind mcu_link mcu_link_checker u_checker (
    .clk24      ( clk24      ),
    .arst_n     ( arst_n     ),
    .req_valid  ( req_valid  ),
    .req_credit ( req_credit ),
    .rsp_valid  ( rsp_valid  ),
    .rsp_credit ( rsp_credit ),
    .irq        ( irq        ),
    .irq_ack    ( irq_ack    ),
    .irq_set    ( u_exec.retire && (u_exec.slot.uop == link_pkg::UOP_IRQ) )
);

`default_nettype wire

// ==== mcu_link.sv ====
// Host to MCU mailbox link top: decode, execute and result stages in the clk24 domain
`timescale 1ns/1ps
`default_nettype none

module mcu_link (
    input  logic                clk24,
    input  logic                arst_n,
    // Host requests
    input  logic                req_valid,
    input  link_pkg::link_req_t req,
    output logic                req_credit,
    // Host responses
    output logic                rsp_valid,
    output link_pkg::link_rsp_t rsp,
    input  logic                rsp_credit,
    // MCU interrupt
    output logic                irq,
    input  logic                irq_ack
);

    logic                uop_valid;
    link_pkg::link_uop_t uop;
    logic                exec_credit;
    logic                rd_valid;
    link_pkg::link_rsp_t rd_data;
    logic                res_credit;

    link_decode u_decode (
        .clk24       ( clk24       ),
        .arst_n      ( arst_n      ),
        .req_valid   ( req_valid   ),
        .req         ( req         ),
        .req_credit  ( req_credit  ),
        .uop_valid   ( uop_valid   ),
        .uop         ( uop         ),
        .exec_credit ( exec_credit )
    );

    link_exec u_exec (
        .clk24       ( clk24       ),
        .arst_n      ( arst_n      ),
        .uop_valid   ( uop_valid   ),
        .uop         ( uop         ),
        .exec_credit ( exec_credit ),
        .rd_valid    ( rd_valid    ),
        .rd_data     ( rd_data     ),
        .res_credit  ( res_credit  ),
        .irq         ( irq         ),
        .irq_ack     ( irq_ack     )
    );

    link_result u_result (
        .clk24       ( clk24       ),
        .arst_n      ( arst_n      ),
        .rd_valid    ( rd_valid    ),
        .rd_data     ( rd_data     ),
        .res_credit  ( res_credit  ),
        .rsp_valid   ( rsp_valid   ),
        .rsp         ( rsp         ),
        .rsp_credit  ( rsp_credit  )
    );

endmodule

`default_nettype wire

// ==== link_result.sv ====
// Link result stage: response queue returning mailbox reads under host credits
`timescale 1ns/1ps
`default_nettype none

`include "link_macros.svh"

module link_result (
    input  logic                clk24,
    input  logic                arst_n,
    input  logic                rd_valid,
    input  link_pkg::link_rsp_t rd_data,
    output logic                res_credit,
    output logic                rsp_valid,
    output link_pkg::link_rsp_t rsp,
    input  logic                rsp_credit
);

    link_pkg::link_rsp_t q [`LINK_RDEPTH];
    link_pkg::link_ptr_t wr_ptr;
    link_pkg::link_ptr_t rd_ptr;
    link_pkg::link_cnt_t count;
    link_pkg::link_cnt_t hcred;
    logic                send;

    // Head leaves only when the host has granted room for it
    always_comb begin
        send = (count != '0) && (hcred != '0);
    end

    always_ff @(posedge clk24 or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            hcred      <= '0;
            rsp_valid  <= 1'b0;
            res_credit <= 1'b0;
        end else begin
            if (rd_valid) begin
                wr_ptr <= wr_ptr + link_pkg::link_ptr_t'(1);
            end
            if (send) begin
                rd_ptr <= rd_ptr + link_pkg::link_ptr_t'(1);
            end
            count      <= count + link_pkg::link_cnt_t'(rd_valid)
                          - link_pkg::link_cnt_t'(send);
            hcred      <= hcred + link_pkg::link_cnt_t'(rsp_credit)
                          - link_pkg::link_cnt_t'(send);
            rsp_valid  <= send;
            // Hand the credit back to execute as the slot frees
            res_credit <= send;
        end
    end

    always_ff @(posedge clk24) begin
        if (rd_valid) begin
            q[wr_ptr] <= rd_data;
        end
        if (send) begin
            rsp <= q[rd_ptr];
        end
    end

endmodule

`default_nettype wire

// ==== link_exec.sv ====
// Link execute stage: mailbox byte-lane writes, read forwarding and MCU interrupt latch
`timescale 1ns/1ps
`default_nettype none

`include "link_macros.svh"

module link_exec (
    input  logic                clk24,
    input  logic                arst_n,
    input  logic                uop_valid,
    input  link_pkg::link_uop_t uop,
    output logic                exec_credit,
    output logic                rd_valid,
    output link_pkg::link_rsp_t rd_data,
    input  logic                res_credit,
    output logic                irq,
    input  logic                irq_ack
);

    link_pkg::link_uop_t slot;
    logic                slot_valid;
    logic [15:0]         mailbox;
    link_pkg::link_cnt_t rcred;
    logic                is_rd;
    logic                retire;

    // Reads hold the slot until result has room
    always_comb begin
        is_rd  = (slot.uop == link_pkg::UOP_RD);
        retire = slot_valid && (!is_rd || (rcred != '0));
    end

    always_ff @(posedge clk24 or negedge arst_n) begin
        if (!arst_n) begin
            slot_valid  <= 1'b0;
            mailbox     <= '0;
            rcred       <= link_pkg::link_cnt_t'(`LINK_RDEPTH);
            exec_credit <= 1'b0;
            rd_valid    <= 1'b0;
            irq         <= 1'b0;
        end else begin
            // Decode holds one credit so a new uop never meets a busy slot
            slot_valid  <= uop_valid || (slot_valid && !retire);
            exec_credit <= retire;
            rd_valid    <= retire && is_rd;
            rcred       <= rcred + link_pkg::link_cnt_t'(res_credit)
                           - link_pkg::link_cnt_t'(retire && is_rd);
            // Each strobe loads its own byte like the port latches
            if (retire) begin
                case (slot.uop)
                    link_pkg::UOP_WR_HI: mailbox[15:8] <= slot.data[15:8];
                    link_pkg::UOP_WR_LO: mailbox[7:0]  <= slot.data[7:0];
                    default: ;
                endcase
            end
            // Set beats a simultaneous ack
            if (retire && (slot.uop == link_pkg::UOP_IRQ)) begin
                irq <= 1'b1;
            end else if (irq_ack) begin
                irq <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk24) begin
        if (uop_valid) begin
            slot <= uop;
        end
        if (retire && is_rd) begin
            rd_data.data <= mailbox;
        end
    end

endmodule

`default_nettype wire

// ==== link_decode.sv ====
// Link decode stage: queues host requests and splits them into byte micro-ops
`timescale 1ns/1ps
`default_nettype none

`include "link_macros.svh"

module link_decode (
    input  logic                clk24,
    input  logic                arst_n,
    input  logic                req_valid,
    input  link_pkg::link_req_t req,
    output logic                req_credit,
    output logic                uop_valid,
    output link_pkg::link_uop_t uop,
    input  logic                exec_credit
);

    // Two-lane writes take two issue slots
    typedef enum logic {
        IDLE,
        SPLIT_LO
    } state_e;

    state_e              state;
    state_e              state_nxt;
    link_pkg::link_req_t q [`LINK_QDEPTH];
    link_pkg::link_ptr_t wr_ptr;
    link_pkg::link_ptr_t rd_ptr;
    link_pkg::link_cnt_t count;
    link_pkg::link_cnt_t ecred;
    link_pkg::link_req_t head;
    link_pkg::link_uop_t uop_nxt;
    logic                empty;
    logic                both_lanes;
    logic                no_lane;
    logic                issue;
    logic                pop;

    always_comb begin
        head       = q[rd_ptr];
        empty      = (count == '0);
        both_lanes = (head.dsn == 2'b00);
        no_lane    = (head.dsn == 2'b11);
        issue      = 1'b0;
        pop        = 1'b0;
        state_nxt  = state;
        uop_nxt    = '{uop: link_pkg::UOP_RD, data: head.data};
        case (state)
            IDLE: begin
                if (!empty) begin
                    case (head.op)
                        link_pkg::OP_WRITE: begin
                            // No byte selected so retire without touching execute
                            if (no_lane) begin
                                pop = 1'b1;
                            end else if (ecred != '0) begin
                                issue = 1'b1;
                                if (both_lanes) begin
                                    uop_nxt.uop = link_pkg::UOP_WR_HI;
                                    state_nxt   = SPLIT_LO;
                                end else begin
                                    pop = 1'b1;
                                    if (head.dsn[1]) begin
                                        uop_nxt.uop = link_pkg::UOP_WR_LO;
                                    end else begin
                                        uop_nxt.uop = link_pkg::UOP_WR_HI;
                                    end
                                end
                            end
                        end
                        link_pkg::OP_READ: begin
                            if (ecred != '0) begin
                                issue       = 1'b1;
                                pop         = 1'b1;
                                uop_nxt.uop = link_pkg::UOP_RD;
                            end
                        end
                        link_pkg::OP_IRQ: begin
                            if (ecred != '0) begin
                                issue       = 1'b1;
                                pop         = 1'b1;
                                uop_nxt.uop = link_pkg::UOP_IRQ;
                            end
                        end
                        // Drop the unused opcode encoding
                        default: pop = 1'b1;
                    endcase
                end
            end
            SPLIT_LO: begin
                // Head stays queued until the low byte goes out
                if (ecred != '0) begin
                    issue       = 1'b1;
                    pop         = 1'b1;
                    uop_nxt.uop = link_pkg::UOP_WR_LO;
                    state_nxt   = IDLE;
                end
            end
            default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk24 or negedge arst_n) begin
        if (!arst_n) begin
            state      <= IDLE;
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            ecred      <= link_pkg::link_cnt_t'(1);
            req_credit <= 1'b0;
            uop_valid  <= 1'b0;
        end else begin
            state <= state_nxt;
            if (req_valid) begin
                wr_ptr <= wr_ptr + link_pkg::link_ptr_t'(1);
            end
            if (pop) begin
                rd_ptr <= rd_ptr + link_pkg::link_ptr_t'(1);
            end
            count      <= count + link_pkg::link_cnt_t'(req_valid) - link_pkg::link_cnt_t'(pop);
            ecred      <= ecred + link_pkg::link_cnt_t'(exec_credit)
                          - link_pkg::link_cnt_t'(issue);
            // Credit goes back the cycle after the pop
            req_credit <= pop;
            uop_valid  <= issue;
        end
    end

    always_ff @(posedge clk24) begin
        if (req_valid) begin
            q[wr_ptr] <= req;
        end
        if (issue) begin
            uop <= uop_nxt;
        end
    end

endmodule

`default_nettype wire

// ==== link_pkg.sv ====
// Mailbox link types for host requests, byte micro-ops and read responses
`default_nettype none

`include "link_macros.svh"

package link_pkg;

    // Host side opcodes
    typedef enum logic [1:0] {
        OP_WRITE = 2'd0,
        OP_READ  = 2'd1,
        OP_IRQ   = 2'd2
    } link_op_e;

    // Byte micro-ops seen by execute
    typedef enum logic [1:0] {
        UOP_WR_HI = 2'd0,
        UOP_WR_LO = 2'd1,
        UOP_RD    = 2'd2,
        UOP_IRQ   = 2'd3
    } link_uop_e;

    // dsn is active low and bit 1 selects the upper byte like UDSn on the CPU
    typedef struct packed {
        link_op_e    op;
        logic [1:0]  dsn;
        logic [15:0] data;
    } link_req_t;

    typedef struct packed {
        link_uop_e   uop;
        logic [15:0] data;
    } link_uop_t;

    typedef struct packed {
        logic [15:0] data;
    } link_rsp_t;

    // Counter and pointer types
    typedef logic [`LINK_CW-1:0] link_cnt_t;
    typedef logic [`LINK_PW-1:0] link_ptr_t;

endpackage

`default_nettype wire

// ==== link_macros.svh ====
// Mailbox link sizes shared by the queues and credit counters

`ifndef LINK_MACROS_SVH
`define LINK_MACROS_SVH

// Request queue depth
// The host also holds this many request credits after reset
`define LINK_QDEPTH 4

// Response queue depth
// Execute starts with this many result credits
`define LINK_RDEPTH 4

// Credit and occupancy counters
// Wide enough to hold a full queue count
`define LINK_CW 3

// Queue pointer width
// Both queues are four deep so pointers wrap on their own
`define LINK_PW 2

`endif
